//--- Bender.yml
package:
  name: exec_backend

sources:
  - files:
      - hw/backend_pkg.sv
      - hw/pipe_reg.sv
      - hw/issue_ctrl.sv
      - hw/alu_exec.sv
      - hw/mul_unit.sv
      - hw/ex2_stage.sv
      - hw/reg_file.sv
      - hw/exec_backend.sv
  - target: test
    files:
      - dv/exec_backend_assert.sv
      - dv/tb_exec_backend.sv

//--- dv/backend_stim.txt
# pc kind rd rs1 rs2 imm is_target commit data, all fields hex
# kind: 0 add 1 sub 2 and 3 or 4 xor 5 addi 6 beq 7 mul
00000000 5 01 00 00 00000005 0 1 00000005
00000004 5 02 01 00 00000007 0 1 0000000c
00000008 0 03 01 02 00000000 0 1 00000011
0000000c 1 04 03 02 00000000 0 1 00000005
00000010 4 05 04 03 00000000 0 1 00000014
00000014 2 06 05 03 00000000 0 1 00000010
00000018 3 07 06 01 00000000 0 1 00000015
0000001c 5 00 07 00 00000100 0 1 00000115
00000020 0 08 00 07 00000000 0 1 00000015
00000024 5 09 00 00 ffffffff 0 1 ffffffff
00000028 5 0a 09 00 00000002 0 1 00000001
0000002c 7 0b 02 04 00000000 0 1 0000003c
00000030 0 0c 0b 01 00000000 0 1 00000041
00000034 7 0d 09 09 00000000 0 1 00000001
00000038 7 0e 0c 07 00000000 0 1 00000555
0000003c 1 0f 0e 0d 00000000 0 1 00000554
00000040 6 00 01 04 00000020 0 1 00000060
00000044 5 10 00 00 00000bad 0 0 00000000
00000048 0 01 01 01 00000000 0 0 00000000
0000004c 5 02 00 00 00000001 0 0 00000000
00000060 5 11 01 00 00000010 1 1 00000015
00000064 6 00 01 02 00000040 0 1 000000a4
00000068 0 12 11 0f 00000000 0 1 00000569
0000006c 6 00 11 08 00000100 0 1 0000016c
00000070 7 13 11 11 00000000 0 0 00000000
0000016c 5 14 13 00 00000003 1 1 00000003
00000170 0 15 14 0a 00000000 0 1 00000004
00000174 7 16 15 0f 00000000 0 1 00001550
00000178 6 00 16 16 00000008 0 1 00000180
0000017c 5 17 00 00 00000001 0 0 00000000
00000180 4 18 16 15 00000000 1 1 00001554

//--- dv/exec_backend_assert.sv
`timescale 1ns/1ps

module exec_backend_assert (
    input logic                   clk,
    input logic                   resetn,
    input logic                   i_issue_valid,
    input backend_pkg::issue_op_t i_issue_op,
    input logic                   o_issue_ready,
    input logic                   o_redir_valid,
    input backend_pkg::redirect_t o_redir,
    input logic                   i_redir_ready,
    input logic                   o_commit_valid
);

    int failures = 0;

    // Issue side holds its request until taken
    assert property (@(posedge clk) disable iff (!resetn)
        i_issue_valid && !o_issue_ready |=> i_issue_valid && $stable(i_issue_op))
        else begin
            failures++;
            $error("Issue request changed before it was accepted");
        end

    assert property (@(posedge clk) disable iff (!resetn)
        o_redir_valid && !i_redir_ready |=> o_redir_valid && $stable(o_redir))
        else begin
            failures++;
            $error("Redirect changed before it was accepted");
        end

    assert property (@(posedge clk) !resetn |-> !o_commit_valid)
        else begin
            failures++;
            $error("Commit reported during reset");
        end

endmodule

bind exec_backend exec_backend_assert exec_backend_assert_i (.*);

//--- dv/tb_exec_backend.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

endmodule

module tb_exec_backend;

    localparam int MUL_CYCLES = 8;
    localparam int OP_LIMIT = 100;
    localparam int DRAIN_LIMIT = 1000;

    logic                   clk;
    logic                   resetn;
    logic                   i_issue_valid;
    backend_pkg::issue_op_t i_issue_op;
    logic                   o_issue_ready;
    logic                   o_redir_valid;
    backend_pkg::redirect_t o_redir;
    logic                   i_redir_ready;
    logic                   o_commit_valid;
    backend_pkg::commit_t   o_commit;

    backend_pkg::issue_op_t ops [$];
    logic [31:0]            exp_pc_q [$];
    logic [4:0]             exp_rd_q [$];
    logic [31:0]            exp_data_q [$];
    logic [31:0]            exp_redir_q [$];
    logic [31:0]            exp_pc;
    logic [4:0]             exp_rd;
    logic [31:0]            exp_data;
    logic [31:0]            exp_target;
    logic [31:0]            rng;
    int                     errors;
    int                     commits_seen;
    int                     commits_expected;
    int                     waited;

    tb_clk_gen #(
        .PERIOD_NS (20)
    ) tb_clk_gen_i (
        .o_clk (clk)
    );

    exec_backend #(
        .XLEN       (32),
        .MUL_CYCLES (MUL_CYCLES)
    ) exec_backend_i (
        .clk            (clk),
        .resetn         (resetn),
        .i_issue_valid  (i_issue_valid),
        .i_issue_op     (i_issue_op),
        .o_issue_ready  (o_issue_ready),
        .o_redir_valid  (o_redir_valid),
        .o_redir        (o_redir),
        .i_redir_ready  (i_redir_ready),
        .o_commit_valid (o_commit_valid),
        .o_commit       (o_commit)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Architectural result of one op, 32-bit wraparound
    function automatic logic [31:0] expected_result(
        input logic [2:0]  kind,
        input logic [31:0] a,
        input logic [31:0] b,
        input logic [31:0] pc,
        input logic [31:0] imm
    );
        case (kind)
            backend_pkg::ADD:  return a + b;
            backend_pkg::SUB:  return a - b;
            backend_pkg::AND:  return a & b;
            backend_pkg::OR:   return a | b;
            backend_pkg::XOR:  return a ^ b;
            backend_pkg::ADDI: return a + imm;
            backend_pkg::BEQ:  return pc + imm;
            default:           return a * b;
        endcase
    endfunction

    task automatic read_stim_file();
        int                     fd;
        int                     n;
        int                     line_no;
        string                  line;
        logic [31:0]            f_pc;
        logic [31:0]            f_kind;
        logic [31:0]            f_rd;
        logic [31:0]            f_rs1;
        logic [31:0]            f_rs2;
        logic [31:0]            f_imm;
        logic [31:0]            f_tgt;
        logic [31:0]            f_commit;
        logic [31:0]            f_data;
        logic [31:0]            ref_regs [32];
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            value;
        logic                   waiting;
        logic                   committed;
        backend_pkg::issue_op_t op;
        fd = $fopen("dv/backend_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/backend_stim.txt");
            errors++;
            return;
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        waiting = 1'b0;
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                        f_pc, f_kind, f_rd, f_rs1, f_rs2, f_imm, f_tgt, f_commit, f_data);
            if (n == 9) begin
                a = ref_regs[f_rs1[4:0]];
                b = ref_regs[f_rs2[4:0]];
                value = expected_result(f_kind[2:0], a, b, f_pc, f_imm);
                // Wrong-path ops until the next target never commit
                committed = !(waiting && !f_tgt[0]);
                if (f_tgt[0]) begin
                    waiting = 1'b0;
                end
                if (committed) begin
                    if (f_kind[2:0] == backend_pkg::BEQ && a == b) begin
                        waiting = 1'b1;
                        exp_redir_q.push_back(value);
                    end
                    if (f_kind[2:0] != backend_pkg::BEQ && f_rd[4:0] != '0) begin
                        ref_regs[f_rd[4:0]] = value;
                    end
                    // A branch has no destination register
                    if (f_kind[2:0] == backend_pkg::BEQ) begin
                        exp_rd_q.push_back('0);
                    end
                    else begin
                        exp_rd_q.push_back(f_rd[4:0]);
                    end
                    exp_pc_q.push_back(f_pc);
                    exp_data_q.push_back(f_data);
                end
                if (f_commit[0] != committed) begin
                    $display("ERROR stim commit flag line %0d got %h expected %h",
                             line_no, f_commit[0], committed);
                    errors++;
                end
                else if (committed && f_data != value) begin
                    $display("ERROR stim data line %0d got %h expected %h",
                             line_no, f_data, value);
                    errors++;
                end
                op.pc = f_pc;
                op.op_kind = backend_pkg::op_kind_t'(f_kind[2:0]);
                op.rd = f_rd[4:0];
                op.rs1 = f_rs1[4:0];
                op.rs2 = f_rs2[4:0];
                op.imm = f_imm;
                op.is_target = f_tgt[0];
                ops.push_back(op);
            end
        end
        $fclose(fd);
    endtask

    // Ready is read 1 ns after the falling edge, once the inputs have settled
    task automatic issue_one_op(input backend_pkg::issue_op_t op);
        int   tries;
        logic accepted;
        tries = 0;
        accepted = 1'b0;
        @(negedge clk);
        i_issue_valid = 1'b1;
        i_issue_op = op;
        while (!accepted && tries < OP_LIMIT) begin
            #1;
            accepted = o_issue_ready;
            if (!accepted) begin
                @(negedge clk);
                tries++;
            end
        end
        if (!accepted) begin
            $display("Issue of the op at pc %h was never accepted", op.pc);
            errors++;
        end
    endtask

    // Random redirect back-pressure and redirect tracking
    initial begin
        rng = 32'h1d2c_947d;
        i_redir_ready = 1'b0;
        forever begin
            @(negedge clk);
            rng = next_random(rng);
            i_redir_ready = rng[0];
            #1;
            if (resetn && o_redir_valid && i_redir_ready) begin
                if (exp_redir_q.size() == 0) begin
                    $display("Redirect to %h was raised with no taken branch", o_redir.pc);
                    errors++;
                end
                else begin
                    exp_target = exp_redir_q.pop_front();
                    if (o_redir.pc !== exp_target) begin
                        $display("ERROR o_redir.pc got %h expected %h", o_redir.pc, exp_target);
                        errors++;
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        if (resetn && o_commit_valid) begin
            commits_seen++;
            if (exp_pc_q.size() == 0) begin
                $display("Commit at pc %h arrived with no commit left to expect", o_commit.pc);
                errors++;
            end
            else begin
                exp_pc = exp_pc_q.pop_front();
                exp_rd = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                if (o_commit.pc !== exp_pc) begin
                    $display("ERROR o_commit.pc got %h expected %h", o_commit.pc, exp_pc);
                    errors++;
                end
                if (o_commit.rd !== exp_rd) begin
                    $display("ERROR o_commit.rd got %h expected %h", o_commit.rd, exp_rd);
                    errors++;
                end
                if (o_commit.data !== exp_data) begin
                    $display("ERROR o_commit.data got %h expected %h", o_commit.data, exp_data);
                    errors++;
                end
            end
        end
    end

    initial begin
        errors = 0;
        commits_seen = 0;
        resetn = 1'b0;
        i_issue_valid = 1'b0;
        i_issue_op = '0;
        read_stim_file();
        commits_expected = exp_pc_q.size();
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        foreach (ops[i]) begin
            issue_one_op(ops[i]);
        end
        @(negedge clk);
        i_issue_valid = 1'b0;
        waited = 0;
        while ((commits_seen < commits_expected || exp_redir_q.size() != 0)
               && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= DRAIN_LIMIT) begin
            $display("Timed out waiting for the remaining commits and redirects");
            errors++;
        end
        errors += exec_backend_i.exec_backend_assert_i.failures;
        $display("Summary: %0d errors, %0d of %0d commits, %0d redirects missing",
                 errors, commits_seen, commits_expected, exp_redir_q.size());
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end
        else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- hw/alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
    input  backend_pkg::issue_op_t           i_op,
    input  logic [backend_pkg::DATA_W-1:0]   i_rs1,
    input  logic [backend_pkg::DATA_W-1:0]   i_rs2,
    output backend_pkg::ex1_bundle_t         o_bundle
);

    always_comb begin
        o_bundle.op = i_op;
        o_bundle.value = '0;
        o_bundle.operand_b = i_rs2;
        o_bundle.taken = 1'b0;
        unique case (i_op.op_kind)
            backend_pkg::ADD:  o_bundle.value = i_rs1 + i_rs2;
            backend_pkg::SUB:  o_bundle.value = i_rs1 - i_rs2;
            backend_pkg::AND:  o_bundle.value = i_rs1 & i_rs2;
            backend_pkg::OR:   o_bundle.value = i_rs1 | i_rs2;
            backend_pkg::XOR:  o_bundle.value = i_rs1 ^ i_rs2;
            backend_pkg::ADDI: o_bundle.value = i_rs1 + i_op.imm;
            backend_pkg::BEQ: begin
                o_bundle.value = i_op.pc + i_op.imm;
                o_bundle.taken = i_rs1 == i_rs2;
                // Branches write no register
                o_bundle.op.rd = '0;
            end
            backend_pkg::MUL: begin
                // Product is formed in EX2
                o_bundle.value = i_rs1;
            end
        endcase
    end

endmodule

//--- hw/backend_pkg.sv
package backend_pkg;

    localparam int NUM_REGS = 32;
    localparam int REG_AW = 5;
    localparam int DATA_W = 32;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        ADDI,
        BEQ,
        MUL
    } op_kind_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        op_kind_t          op_kind;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [DATA_W-1:0] imm;
        // First operation at a redirect destination
        logic              is_target;
    } issue_op_t;

    typedef struct packed {
        issue_op_t         op;
        // ALU result, branch target, or multiplicand
        logic [DATA_W-1:0] value;
        logic [DATA_W-1:0] operand_b;
        logic              taken;
    } ex1_bundle_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [REG_AW-1:0] rd;
        logic [DATA_W-1:0] data;
    } commit_t;

    typedef struct packed {
        // Stage holds an op that writes rd
        logic              rd_valid;
        // Result is ready to forward
        logic              value_valid;
        logic [REG_AW-1:0] rd;
        logic [DATA_W-1:0] value;
    } bypass_t;

endpackage

//--- hw/ex2_stage.sv
`timescale 1ns/1ps

module ex2_stage #(
    parameter int MUL_CYCLES = 8
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              i_valid,
    input  backend_pkg::ex1_bundle_t          i_bundle,
    output logic                              o_ready,
    input  logic                              i_redir_ready,
    output backend_pkg::bypass_t              o_byp,
    output logic                              o_wr_en,
    output logic [backend_pkg::REG_AW-1:0]    o_wr_sel,
    output logic [backend_pkg::DATA_W-1:0]    o_wr_data,
    output logic                              o_commit_valid,
    output backend_pkg::commit_t              o_commit,
    output logic                              o_squash_start,
    output logic                              o_redir_valid,
    output backend_pkg::redirect_t            o_redir
);

    logic                           busy_q;
    logic                           is_mul_q;
    logic                           taken_q;
    logic [backend_pkg::DATA_W-1:0] pc_q;
    logic [backend_pkg::REG_AW-1:0] rd_q;
    logic [backend_pkg::DATA_W-1:0] value_q;
    logic                           accept;
    logic                           in_is_mul;
    logic                           mul_done;
    logic [backend_pkg::DATA_W-1:0] mul_product;
    logic                           redir_in_ready;
    backend_pkg::redirect_t         redir_target;

    assign in_is_mul = i_bundle.op.op_kind == backend_pkg::MUL;

    // Blocked while an earlier redirect waits for the fetch side
    assign o_ready = (!busy_q || o_commit_valid) && redir_in_ready;
    // Op arriving with the squash is on the wrong path
    assign accept = i_valid && o_ready && !o_squash_start;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy_q <= 1'b0;
        end
        else if (accept) begin
            busy_q <= 1'b1;
        end
        else if (o_commit_valid) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            is_mul_q <= in_is_mul;
            taken_q <= i_bundle.taken;
            pc_q <= i_bundle.op.pc;
            rd_q <= i_bundle.op.rd;
            value_q <= i_bundle.value;
        end
    end

    mul_unit #(
        .MUL_CYCLES (MUL_CYCLES)
    ) mul_unit_i (
        .clk       (clk),
        .resetn    (resetn),
        .i_start   (accept && in_is_mul),
        .i_a       (i_bundle.value),
        .i_b       (i_bundle.operand_b),
        .o_done    (mul_done),
        .o_product (mul_product)
    );

    assign o_commit_valid = busy_q && (!is_mul_q || mul_done);
    assign o_squash_start = o_commit_valid && taken_q;

    assign o_wr_en = o_commit_valid;
    assign o_wr_sel = rd_q;
    assign o_wr_data = is_mul_q ? mul_product : value_q;

    assign o_commit.pc = pc_q;
    assign o_commit.rd = rd_q;
    assign o_commit.data = o_wr_data;

    assign o_byp.rd_valid = busy_q && rd_q != '0;
    assign o_byp.value_valid = !is_mul_q || mul_done;
    assign o_byp.rd = rd_q;
    assign o_byp.value = o_wr_data;

    assign redir_target.pc = value_q;

    pipe_reg #(
        .payload_t (backend_pkg::redirect_t)
    ) redir_reg_i (
        .clk     (clk),
        .resetn  (resetn),
        .i_valid (o_squash_start),
        .i_data  (redir_target),
        .i_flush (1'b0),
        .o_ready (redir_in_ready),
        .i_ready (i_redir_ready),
        .o_valid (o_redir_valid),
        .o_data  (o_redir)
    );

endmodule

//--- hw/exec_backend.sv
`timescale 1ns/1ps

module exec_backend #(
    parameter int XLEN = 32,
    parameter int MUL_CYCLES = 8
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       i_issue_valid,
    input  backend_pkg::issue_op_t     i_issue_op,
    output logic                       o_issue_ready,
    output logic                       o_redir_valid,
    output backend_pkg::redirect_t     o_redir,
    input  logic                       i_redir_ready,
    output logic                       o_commit_valid,
    output backend_pkg::commit_t       o_commit
);

    if (XLEN != backend_pkg::DATA_W) begin : g_xlen_check
        $error("XLEN does not match the package data width");
    end

    logic [backend_pkg::REG_AW-1:0] rs1_sel;
    logic [backend_pkg::REG_AW-1:0] rs2_sel;
    logic [backend_pkg::DATA_W-1:0] rf_rs1;
    logic [backend_pkg::DATA_W-1:0] rf_rs2;
    logic [backend_pkg::DATA_W-1:0] iss_rs1;
    logic [backend_pkg::DATA_W-1:0] iss_rs2;
    logic                           iss_valid;
    logic                           ex1_in_ready;
    backend_pkg::ex1_bundle_t       ex1_next;
    logic                           ex1_valid;
    backend_pkg::ex1_bundle_t       ex1_bundle;
    backend_pkg::bypass_t           ex1_byp;
    backend_pkg::bypass_t           ex2_byp;
    logic                           ex2_ready;
    logic                           wr_en;
    logic [backend_pkg::REG_AW-1:0] wr_sel;
    logic [backend_pkg::DATA_W-1:0] wr_data;
    logic                           squash_start;

    issue_ctrl issue_ctrl_i (
        .clk            (clk),
        .resetn         (resetn),
        .i_valid        (i_issue_valid),
        .i_op           (i_issue_op),
        .o_ready        (o_issue_ready),
        .o_rs1_sel      (rs1_sel),
        .o_rs2_sel      (rs2_sel),
        .i_rs1_data     (rf_rs1),
        .i_rs2_data     (rf_rs2),
        .i_ex1_byp      (ex1_byp),
        .i_ex2_byp      (ex2_byp),
        .i_ex1_ready    (ex1_in_ready),
        .i_squash_start (squash_start),
        .o_rs1          (iss_rs1),
        .o_rs2          (iss_rs2),
        .o_valid        (iss_valid)
    );

    alu_exec alu_exec_i (
        .i_op     (i_issue_op),
        .i_rs1    (iss_rs1),
        .i_rs2    (iss_rs2),
        .o_bundle (ex1_next)
    );

    pipe_reg #(
        .payload_t (backend_pkg::ex1_bundle_t)
    ) ex1_reg_i (
        .clk     (clk),
        .resetn  (resetn),
        .i_valid (iss_valid),
        .i_data  (ex1_next),
        .i_flush (squash_start),
        .o_ready (ex1_in_ready),
        .i_ready (ex2_ready),
        .o_valid (ex1_valid),
        .o_data  (ex1_bundle)
    );

    // EX1 entry being squashed must not forward
    assign ex1_byp.rd_valid = ex1_valid && !squash_start && ex1_bundle.op.rd != '0;
    assign ex1_byp.value_valid = ex1_bundle.op.op_kind != backend_pkg::MUL;
    assign ex1_byp.rd = ex1_bundle.op.rd;
    assign ex1_byp.value = ex1_bundle.value;

    ex2_stage #(
        .MUL_CYCLES (MUL_CYCLES)
    ) ex2_stage_i (
        .clk            (clk),
        .resetn         (resetn),
        .i_valid        (ex1_valid),
        .i_bundle       (ex1_bundle),
        .o_ready        (ex2_ready),
        .i_redir_ready  (i_redir_ready),
        .o_byp          (ex2_byp),
        .o_wr_en        (wr_en),
        .o_wr_sel       (wr_sel),
        .o_wr_data      (wr_data),
        .o_commit_valid (o_commit_valid),
        .o_commit       (o_commit),
        .o_squash_start (squash_start),
        .o_redir_valid  (o_redir_valid),
        .o_redir        (o_redir)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .resetn    (resetn),
        .i_ra_sel  (rs1_sel),
        .i_rb_sel  (rs2_sel),
        .i_w_en    (wr_en),
        .i_w_sel   (wr_sel),
        .i_w_data  (wr_data),
        .o_ra_data (rf_rs1),
        .o_rb_data (rf_rs2)
    );

endmodule

//--- hw/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                i_valid,
    input  backend_pkg::issue_op_t              i_op,
    output logic                                o_ready,
    output logic [backend_pkg::REG_AW-1:0]      o_rs1_sel,
    output logic [backend_pkg::REG_AW-1:0]      o_rs2_sel,
    input  logic [backend_pkg::DATA_W-1:0]      i_rs1_data,
    input  logic [backend_pkg::DATA_W-1:0]      i_rs2_data,
    input  backend_pkg::bypass_t                i_ex1_byp,
    input  backend_pkg::bypass_t                i_ex2_byp,
    input  logic                                i_ex1_ready,
    input  logic                                i_squash_start,
    output logic [backend_pkg::DATA_W-1:0]      o_rs1,
    output logic [backend_pkg::DATA_W-1:0]      o_rs2,
    output logic                                o_valid
);

    localparam int W = backend_pkg::DATA_W;

    // Returns {hazard, value}; EX1 is the youngest producer
    function automatic logic [W:0] pick_operand(
        input logic [backend_pkg::REG_AW-1:0] sel,
        input logic [W-1:0]                   rf_data,
        input backend_pkg::bypass_t           ex1,
        input backend_pkg::bypass_t           ex2
    );
        logic         hazard;
        logic [W-1:0] value;
        hazard = 1'b0;
        value = rf_data;
        if (ex1.rd_valid && ex1.rd == sel) begin
            if (ex1.value_valid) begin
                value = ex1.value;
            end
            else begin
                hazard = 1'b1;
            end
        end
        else if (ex2.rd_valid && ex2.rd == sel) begin
            if (ex2.value_valid) begin
                value = ex2.value;
            end
            else begin
                hazard = 1'b1;
            end
        end
        return {hazard, value};
    endfunction

    logic [W:0] rs1_pick;
    logic [W:0] rs2_pick;
    logic       hazard;
    logic       drop;
    logic       wait_target_q;
    logic       live_q;

    assign o_rs1_sel = i_op.rs1;
    assign o_rs2_sel = i_op.rs2;
    assign rs1_pick = pick_operand(i_op.rs1, i_rs1_data, i_ex1_byp, i_ex2_byp);
    assign rs2_pick = pick_operand(i_op.rs2, i_rs2_data, i_ex1_byp, i_ex2_byp);
    assign o_rs1 = rs1_pick[W-1:0];
    assign o_rs2 = rs2_pick[W-1:0];

    // ADDI ignores rs2
    assign hazard = rs1_pick[W] || (rs2_pick[W] && i_op.op_kind != backend_pkg::ADDI);

    // Wrong-path ops are consumed here and never reach EX1
    assign drop = (wait_target_q || i_squash_start) && !i_op.is_target;

    assign o_ready = live_q && (drop || (!hazard && i_ex1_ready));
    assign o_valid = live_q && i_valid && !drop && !hazard;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            live_q <= 1'b0;
            wait_target_q <= 1'b0;
        end
        else begin
            live_q <= 1'b1;
            if (i_squash_start) begin
                wait_target_q <= 1'b1;
            end
            if (i_valid && o_ready && i_op.is_target) begin
                wait_target_q <= 1'b0;
            end
        end
    end

endmodule

//--- hw/mul_unit.sv
`timescale 1ns/1ps

module mul_unit #(
    parameter int MUL_CYCLES = 8
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              i_start,
    input  logic [backend_pkg::DATA_W-1:0]    i_a,
    input  logic [backend_pkg::DATA_W-1:0]    i_b,
    output logic                              o_done,
    output logic [backend_pkg::DATA_W-1:0]    o_product
);

    localparam int W = backend_pkg::DATA_W;
    localparam int STEP_BITS = W / MUL_CYCLES;
    localparam int CNT_W = $clog2(MUL_CYCLES + 1);

    if (W % MUL_CYCLES != 0) begin : g_bad_cycles
        $error("MUL_CYCLES must divide the data width");
    end

    logic [W-1:0]     a_q;
    logic [W-1:0]     b_q;
    logic [W-1:0]     acc_q;
    logic [W-1:0]     step_sum;
    logic [CNT_W-1:0] cnt_q;
    logic             done_q;

    // STEP_BITS multiplier bits per cycle
    always_comb begin
        step_sum = acc_q;
        for (int i = 0; i < STEP_BITS; i++) begin
            if (b_q[i]) begin
                step_sum = step_sum + (a_q << i);
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cnt_q <= '0;
            done_q <= 1'b0;
        end
        else begin
            done_q <= 1'b0;
            if (i_start) begin
                cnt_q <= CNT_W'(MUL_CYCLES);
            end
            else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
                done_q <= cnt_q == CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            a_q <= i_a;
            b_q <= i_b;
            acc_q <= '0;
        end
        else if (cnt_q != '0) begin
            acc_q <= step_sum;
            a_q <= a_q << STEP_BITS;
            b_q <= b_q >> STEP_BITS;
        end
    end

    assign o_done = done_q;
    assign o_product = acc_q;

endmodule

//--- hw/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     i_valid,
    input  payload_t i_data,
    input  logic     i_flush,
    output logic     o_ready,
    input  logic     i_ready,
    output logic     o_valid,
    output payload_t o_data
);

    // Flush discards the held entry but still lets a new one in
    assign o_ready = !o_valid || i_ready || i_flush;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_valid <= 1'b0;
        end
        else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            o_data <= i_data;
        end
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic [backend_pkg::REG_AW-1:0]    i_ra_sel,
    input  logic [backend_pkg::REG_AW-1:0]    i_rb_sel,
    input  logic                              i_w_en,
    input  logic [backend_pkg::REG_AW-1:0]    i_w_sel,
    input  logic [backend_pkg::DATA_W-1:0]    i_w_data,
    output logic [backend_pkg::DATA_W-1:0]    o_ra_data,
    output logic [backend_pkg::DATA_W-1:0]    o_rb_data
);

    logic [backend_pkg::DATA_W-1:0] regs_q [backend_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < backend_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end
        // x0 is never written
        else if (i_w_en && i_w_sel != '0) begin
            regs_q[i_w_sel] <= i_w_data;
        end
    end

    assign o_ra_data = regs_q[i_ra_sel];
    assign o_rb_data = regs_q[i_rb_sel];

endmodule

//--- list.f
hw/backend_pkg.sv
hw/pipe_reg.sv
hw/issue_ctrl.sv
hw/alu_exec.sv
hw/mul_unit.sv
hw/ex2_stage.sv
hw/reg_file.sv
hw/exec_backend.sv
dv/exec_backend_assert.sv
dv/tb_exec_backend.sv
